//--- logic/pixelCpu_config.svh
`ifndef PIXEL_CPU_CONFIG_SVH
`define PIXEL_CPU_CONFIG_SVH

// Register, memory and PC word width
`define DATA_WIDTH 16

// Register file size
`define REG_COUNT 32

// Written by branch-and-link and read by return
`define LINK_REG 29

// Words in each colour bank
`define MEM_DEPTH 64

`endif

//--- logic/pixelCpuPkg.sv
package pixelCpuPkg;

    typedef enum logic [1:0] {
        red   = 2'b00,
        green = 2'b01,
        blue  = 2'b10
    } colorSel;

    localparam logic [1:0] aluPassB = 2'b00;   // MOV and loads
    localparam logic [1:0] aluSub   = 2'b01;   // Compare and store address
    localparam logic [1:0] aluByOp  = 2'b10;   // Arithmetic class picks by op

    typedef struct packed {
        logic [1:0] instrClass;
        logic [1:0] op;
        logic       inm;
        logic [4:0] rd;
        logic [4:0] rn;
        logic [4:0] rm;                        // Second source register
        logic [3:0] spare;
    } regFields;

    typedef struct packed {
        logic [1:0] instrClass;
        logic [1:0] op;
        logic       inm;
        logic [4:0] rd;
        logic [4:0] rn;
        logic [8:0] imm9;                      // Immediate or jump offset
    } immFields;

    // Same 24-bit word seen two ways
    typedef union packed {
        regFields regForm;
        immFields immForm;
    } instrWord;

    typedef struct packed {
        logic       regWrite;
        logic       aluSrc;                    // 1 takes imm9 as operand B
        logic       memWrite;
        logic       resultSrc;                 // 1 writes back memory data
        logic       branch;
        logic [1:0] aluOp;
        colorSel    color;                     // Bank for loads and stores
        logic       jump;
        logic       pcDirection;               // 1 jumps backwards
        logic       pcReturn;
        logic       branchLink;
    } ctrlSignals;

endpackage

//--- logic/mainDecoder.sv
`timescale 1ns/100ps

module mainDecoder import pixelCpuPkg::*; (
    input  logic [1:0] instrClass,             // Instruction class
    input  logic [1:0] op,                     // Operation within class
    input  logic       inm,                    // Immediate or direction bit
    output ctrlSignals ctrl
);

    always_comb begin
        ctrl = '0;                             // Everything idle by default

        case (instrClass)
            2'b00: begin                       // Arithmetic
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = inm;
                ctrl.aluOp    = aluByOp;
            end

            2'b01: begin                       // Data read
                ctrl.aluSrc   = inm;
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = aluPassB;
                case (op)
                    2'b00: begin               // MOV
                        ctrl.resultSrc = 1'b0;
                    end
                    2'b01: begin               // LDR
                        ctrl.resultSrc = 1'b1;
                        ctrl.color     = red;
                        ctrl.aluSrc    = 1'b0; // Address from rm
                    end
                    2'b10: begin               // LDG
                        ctrl.resultSrc = 1'b1;
                        ctrl.color     = green;
                        ctrl.aluSrc    = 1'b0;
                    end
                    default: begin             // LDB
                        ctrl.resultSrc = 1'b1;
                        ctrl.color     = blue;
                        ctrl.aluSrc    = 1'b0;
                    end
                endcase
            end

            2'b10: begin                       // Flow control
                case (op)
                    2'b00: begin               // Relative jump
                        ctrl.jump        = 1'b1;
                        ctrl.pcDirection = inm;
                    end
                    2'b01: begin               // Branch and link
                        ctrl.regWrite   = 1'b1;
                        ctrl.jump       = 1'b1;
                        ctrl.branchLink = 1'b1;
                    end
                    2'b10: begin               // Compare and branch on equal
                        ctrl.branch      = 1'b1;
                        ctrl.pcDirection = inm;
                        ctrl.aluOp       = aluSub;
                    end
                    default: ;                 // Not defined
                endcase
            end

            default: begin                     // Data write and return
                ctrl.aluSrc = inm;
                case (op)
                    2'b00: begin               // RET
                        ctrl.jump     = 1'b1;
                        ctrl.pcReturn = 1'b1;
                    end
                    2'b01: begin               // STR
                        ctrl.memWrite = 1'b1;
                        ctrl.aluOp    = aluSub; // Address rn minus rm
                        ctrl.color    = red;
                        ctrl.aluSrc   = 1'b0;
                    end
                    2'b10: begin               // STG
                        ctrl.memWrite = 1'b1;
                        ctrl.aluOp    = aluSub;
                        ctrl.color    = green;
                        ctrl.aluSrc   = 1'b0;
                    end
                    default: begin             // STB
                        ctrl.memWrite = 1'b1;
                        ctrl.aluOp    = aluSub;
                        ctrl.color    = blue;
                        ctrl.aluSrc   = 1'b0;
                    end
                endcase
            end
        endcase
    end

endmodule

//--- logic/aluUnit.sv
`timescale 1ns/100ps
`include "pixelCpu_config.svh"

module aluUnit import pixelCpuPkg::*; (
    input  logic [`DATA_WIDTH-1:0] regA,
    input  logic [`DATA_WIDTH-1:0] regB,
    input  logic [8:0]             imm,       // Zero-extended below
    input  logic                   aluSrc,
    input  logic [1:0]             aluOp,
    input  logic [1:0]             op,
    output logic [`DATA_WIDTH-1:0] result,
    output logic                   zero        // Compare found equal operands
);

    logic [`DATA_WIDTH-1:0] operandB;

    assign operandB = aluSrc ? {{(`DATA_WIDTH-9){1'b0}}, imm} : regB;

    always_comb begin
        case (aluOp)
            aluPassB: result = operandB;       // MOV and load address
            aluSub:   result = regA - operandB;
            aluByOp: begin
                case (op)
                    2'b00:   result = regA + operandB;
                    2'b01:   result = regA - operandB;
                    2'b10:   result = regA & operandB;
                    default: result = regA | operandB;
                endcase
            end
            default:  result = operandB;
        endcase
    end

    assign zero = (result == '0);              // Only used when branch is set

endmodule

//--- logic/registerFile.sv
`timescale 1ns/100ps
`include "pixelCpu_config.svh"

module registerFile import pixelCpuPkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  ctrlSignals             ctrl,
    input  logic [4:0]             rn,
    input  logic [4:0]             rm,
    input  logic [4:0]             rd,
    input  logic [`DATA_WIDTH-1:0] aluResult,
    input  logic [`DATA_WIDTH-1:0] memData,
    input  logic [`DATA_WIDTH-1:0] pcPlusOne,  // Return address for BL
    output logic [`DATA_WIDTH-1:0] regA,
    output logic [`DATA_WIDTH-1:0] regB,
    output logic [`DATA_WIDTH-1:0] regD,      // Store data
    output logic [`DATA_WIDTH-1:0] linkValue
);

    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];
    logic [`DATA_WIDTH-1:0] writeData;

    assign writeData = ctrl.resultSrc ? memData : aluResult;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) regs[i] <= '0;
        end else if (ctrl.branchLink) begin
            regs[`LINK_REG] <= pcPlusOne;      // Wins over regWrite
        end else if (ctrl.regWrite) begin
            regs[rd] <= writeData;
        end
    end

    assign regA      = regs[rn];
    assign regB      = regs[rm];
    assign regD      = regs[rd];
    assign linkValue = regs[`LINK_REG];        // Always visible to PC logic

endmodule

//--- logic/colorMemory.sv
`timescale 1ns/100ps
`include "pixelCpu_config.svh"

module colorMemory import pixelCpuPkg::*; #(
    parameter int addrWidth = $clog2(`MEM_DEPTH)
) (
    input  logic                   clk,
    input  ctrlSignals             ctrl,
    input  logic [`DATA_WIDTH-1:0] addr,      // ALU result, low bits used
    input  logic [`DATA_WIDTH-1:0] storeData,
    output logic [`DATA_WIDTH-1:0] loadData,
    input  logic                   displayRead,
    input  colorSel                displayColor,
    input  logic [addrWidth-1:0]   displayAddr,
    output logic [`DATA_WIDTH-1:0] displayData,
    output logic                   displayValid,
    input  logic                   reset
);

    logic [`DATA_WIDTH-1:0] banks [3][`MEM_DEPTH]; // Red, green, blue
    logic [addrWidth-1:0]   cpuAddr;
    logic                   storeHit;              // Store to the word being scanned

    assign cpuAddr  = addr[addrWidth-1:0];
    assign loadData = banks[ctrl.color][cpuAddr];  // Combinational load
    assign storeHit = ctrl.memWrite && (ctrl.color == displayColor)
                      && (cpuAddr == displayAddr);

    always_ff @(posedge clk) begin
        if (ctrl.memWrite && ctrl.color != 2'b11) begin
            banks[ctrl.color][cpuAddr] <= storeData;
        end
        if (displayRead) begin                      // Write-first for the scanner
            displayData <= storeHit ? storeData : banks[displayColor][displayAddr];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) displayValid <= 1'b0;
        else       displayValid <= displayRead;     // One pulse per strobe
    end

endmodule

//--- logic/programCounter.sv
`timescale 1ns/100ps
`include "pixelCpu_config.svh"

module programCounter import pixelCpuPkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  ctrlSignals             ctrl,
    input  logic [8:0]             offset,    // Relative jump distance
    input  logic                   zero,
    input  logic [`DATA_WIDTH-1:0] linkValue,
    output logic [`DATA_WIDTH-1:0] pc,
    output logic [`DATA_WIDTH-1:0] pcPlusOne
);

    logic [`DATA_WIDTH-1:0] offsetExt;
    logic [`DATA_WIDTH-1:0] pcTarget;
    logic [`DATA_WIDTH-1:0] pcNext;
    logic                   takeJump;

    assign offsetExt = {{(`DATA_WIDTH-9){1'b0}}, offset};
    assign pcPlusOne = pc + 1'b1;
    assign pcTarget  = ctrl.pcDirection ? pc - offsetExt : pc + offsetExt;
    assign takeJump  = ctrl.jump || (ctrl.branch && zero);

    always_comb begin
        if (ctrl.pcReturn)  pcNext = linkValue;  // RET has top priority
        else if (takeJump)  pcNext = pcTarget;
        else                pcNext = pcPlusOne;
    end

    always_ff @(posedge clk) begin
        if (reset) pc <= '0;
        else       pc <= pcNext;
    end

endmodule

//--- logic/pixelCpu.sv
`timescale 1ns/100ps
`include "pixelCpu_config.svh"

module pixelCpu import pixelCpuPkg::*; #(
    parameter int addrWidth = $clog2(`MEM_DEPTH)
) (
    input  logic                   clk,
    input  logic                   reset,
    output logic [`DATA_WIDTH-1:0] instrAddr,    // To program ROM
    input  instrWord               instr,
    input  logic                   displayRead,
    input  colorSel                displayColor,
    input  logic [addrWidth-1:0]   displayAddr,
    output logic [`DATA_WIDTH-1:0] displayData,
    output logic                   displayValid
);

    ctrlSignals             ctrl;
    logic [`DATA_WIDTH-1:0] regA, regB, regD;
    logic [`DATA_WIDTH-1:0] aluResult;
    logic [`DATA_WIDTH-1:0] memData;
    logic [`DATA_WIDTH-1:0] linkValue;
    logic [`DATA_WIDTH-1:0] pcPlusOne;
    logic                   zero;
    logic [4:0]             rd, rn, rm;
    logic [8:0]             imm9;

    assign rd   = instr.regForm.rd;
    assign rn   = instr.regForm.rn;
    assign rm   = instr.regForm.rm;              // Register view
    assign imm9 = instr.immForm.imm9;            // Immediate view of same bits

    mainDecoder u_decoder (
        .instrClass(instr.regForm.instrClass), .op(instr.regForm.op),
        .inm(instr.regForm.inm), .ctrl(ctrl)
    );

    aluUnit u_alu (
        .regA(regA), .regB(regB), .imm(imm9), .aluSrc(ctrl.aluSrc), .aluOp(ctrl.aluOp),
        .op(instr.regForm.op), .result(aluResult), .zero(zero)
    );

    registerFile u_regs (
        .clk(clk), .reset(reset), .ctrl(ctrl), .rn(rn), .rm(rm), .rd(rd),
        .aluResult(aluResult), .memData(memData), .pcPlusOne(pcPlusOne),
        .regA(regA), .regB(regB), .regD(regD), .linkValue(linkValue)
    );

    colorMemory #(.addrWidth(addrWidth)) u_mem (
        .clk(clk), .ctrl(ctrl), .addr(aluResult), .storeData(regD), .loadData(memData),
        .displayRead(displayRead), .displayColor(displayColor), .displayAddr(displayAddr),
        .displayData(displayData), .displayValid(displayValid), .reset(reset)
    );

    programCounter u_pc (
        .clk(clk), .reset(reset), .ctrl(ctrl), .offset(imm9), .zero(zero),
        .linkValue(linkValue), .pc(instrAddr), .pcPlusOne(pcPlusOne)
    );

endmodule

//--- verification/pixelCpuTb.sv
`timescale 1ns/100ps
`include "pixelCpu_config.svh"

module pixelCpuTb import pixelCpuPkg::*; ();

    localparam int clkPeriod = 40;
    localparam int progDepth = 64;
    localparam int runLimit = 60;                  // Max cycles for a program to reach its halt
    localparam int readBudget = 40;                // Display reads per test, upper bound
    localparam int testCount = 6;
    localparam int watchdogCycles = testCount * (3 + runLimit + readBudget) + 50;
    localparam logic [23:0] nopWord = 24'hB00000;  // Flow class op 3 with all controls idle
    localparam logic [23:0] haltWord = 24'h800000; // Jump by zero spins in place

    logic                   clk = 1'b0;
    logic                   reset;
    logic [`DATA_WIDTH-1:0] instrAddr;
    instrWord               instr;
    logic                   displayRead;
    colorSel                displayColor;
    logic [5:0]             displayAddr;
    logic [`DATA_WIDTH-1:0] displayData;
    logic                   displayValid;
    logic [23:0]            prog [progDepth];     // Program ROM contents
    int                     errors = 0;
    int                     lastErrors = 0;
    int                     passCount = 0;
    int                     failCount = 0;

    always #(clkPeriod / 2) clk = ~clk;

    assign instr = (instrAddr < progDepth) ? prog[instrAddr[5:0]] : nopWord;

    pixelCpu u_dut (
        .clk(clk), .reset(reset), .instrAddr(instrAddr), .instr(instr),
        .displayRead(displayRead), .displayColor(displayColor), .displayAddr(displayAddr),
        .displayData(displayData), .displayValid(displayValid)
    );

    // Field order is class, op, inm, rd, rn and then imm9 or rm plus 4 spare bits
    function automatic logic [23:0] immInstr(input logic [1:0] cls, input logic [1:0] op,
            input logic inm, input logic [4:0] rd, input logic [4:0] rn, input logic [8:0] imm);
        return {cls, op, inm, rd, rn, imm};
    endfunction

    function automatic logic [23:0] regInstr(input logic [1:0] cls, input logic [1:0] op,
            input logic [4:0] rd, input logic [4:0] rn, input logic [4:0] rm);
        return {cls, op, 1'b0, rd, rn, rm, 4'b0000};
    endfunction

    task automatic compare(input string name, input logic [31:0] expected,
            input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch %s expected 0x%0h actual 0x%0h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic clearProgram();
        for (int i = 0; i < progDepth; i++) prog[i] = nopWord;
    endtask

    task automatic resetCpu(input string name);
        @(posedge clk);
        #1;
        reset = 1'b1;
        displayRead = 1'b1;                        // Strobe held through reset
        @(posedge clk);
        @(negedge clk);
        compare({name, " pc in reset"}, 0, instrAddr);
        compare({name, " valid in reset"}, 0, displayValid);
        @(posedge clk);
        #1;
        reset = 1'b0;                              // Two cycles held
        displayRead = 1'b0;
        compare({name, " pc after reset"}, 0, instrAddr);
        compare({name, " valid after reset"}, 0, displayValid);
    endtask

    task automatic runToAddr(input string name, input int target);
        int n;
        n = 0;
        while (instrAddr !== 16'(target) && n < runLimit) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (instrAddr !== 16'(target)) begin
            $display("%s: program never reached address %0d", name, target);
            errors++;
        end
    endtask

    task automatic checkPixel(input string name, input colorSel color, input int addr,
            input logic [15:0] expected);
        @(posedge clk);
        #1;
        displayRead = 1'b1;
        displayColor = color;
        displayAddr = 6'(addr);
        @(posedge clk);
        #1;
        displayRead = 1'b0;
        @(negedge clk);                            // Pulse sits in the cycle after the strobe
        if (displayValid !== 1'b1) begin
            $display("%s: no display valid pulse for a read of address %0d", name, addr);
            errors++;
        end
        compare(name, expected, displayData);
    endtask

    task automatic finishTest(input string name);
        if (errors == lastErrors) begin
            $display("%s: ok", name);
            passCount++;
        end else begin
            $display("%s: %0d errors", name, errors - lastErrors);
            failCount++;
        end
        lastErrors = errors;
    endtask

    task automatic resetBehavior();
        clearProgram();
        resetCpu("reset");
        for (int k = 0; k < 8; k++) begin
            @(negedge clk);
            compare("reset step", k, instrAddr);   // One address per cycle
        end
    endtask

    task automatic arithmeticOps();
        logic [15:0] a, b;
        logic [15:0] expected [10];
        logic [4:0]  srcReg;
        a = 16'($urandom % 512);
        b = 16'($urandom % 512);
        clearProgram();
        prog[0] = immInstr(2'd1, 2'd0, 1'b1, 5'd1, 5'd0, a[8:0]);   // MOV r1, #a
        prog[1] = immInstr(2'd1, 2'd0, 1'b1, 5'd2, 5'd0, b[8:0]);   // MOV r2, #b
        for (int i = 0; i < 8; i++) begin
            case (i % 4)
                0:       expected[i] = a + b;
                1:       expected[i] = a - b;           // Wraps at 16 bits
                2:       expected[i] = a & b;
                default: expected[i] = a | b;
            endcase
            if (i < 4) prog[2 + i] = immInstr(2'd0, 2'(i), 1'b1, 5'(3 + i), 5'd1, b[8:0]);
            else       prog[2 + i] = regInstr(2'd0, 2'(i), 5'(3 + i), 5'd1, 5'd2);
        end
        prog[10] = regInstr(2'd1, 2'd0, 5'd11, 5'd0, 5'd2);         // MOV r11, r2
        expected[8] = b;
        expected[9] = a;
        for (int i = 0; i < 10; i++) begin
            srcReg = (i == 9) ? 5'd1 : 5'(3 + i);
            prog[11 + 2 * i] = immInstr(2'd1, 2'd0, 1'b1, 5'd20, 5'd0, 9'(8 + i));
            prog[12 + 2 * i] = regInstr(2'd3, 2'd1, srcReg, 5'd20, 5'd0); // STR at r20 - r0
        end
        prog[31] = haltWord;
        resetCpu("arithmetic");
        runToAddr("arithmetic", 31);
        for (int i = 0; i < 10; i++) checkPixel("arithmetic", red, 8 + i, expected[i]);
    endtask

    task automatic colourBanks();
        logic [15:0] value [3];
        for (int k = 0; k < 3; k++) value[k] = 16'(($urandom % 128) + 128 * k);
        clearProgram();
        prog[3] = immInstr(2'd1, 2'd0, 1'b1, 5'd4, 5'd0, 9'd5);     // Shared address 5
        for (int k = 0; k < 3; k++) begin
            prog[k] = immInstr(2'd1, 2'd0, 1'b1, 5'(1 + k), 5'd0, value[k][8:0]);
            prog[4 + k] = regInstr(2'd3, 2'(1 + k), 5'(1 + k), 5'd4, 5'd0);  // STR, STG, STB
            prog[7 + k] = regInstr(2'd1, 2'(1 + k), 5'(5 + k), 5'd0, 5'd4);  // LDR, LDG, LDB
            prog[10 + k] = immInstr(2'd1, 2'd0, 1'b1, 5'(8 + k), 5'd0, 9'(12 + k));
            prog[13 + k] = regInstr(2'd3, 2'd1, 5'(5 + k), 5'(8 + k), 5'd0);
        end
        prog[16] = haltWord;
        resetCpu("banks");
        runToAddr("banks", 16);
        for (int k = 0; k < 3; k++) checkPixel("banks store", colorSel'(k), 5, value[k]);
        for (int k = 0; k < 3; k++) checkPixel("banks load", red, 12 + k, value[k]);
    endtask

    // Offsets below 16 leave the rm field at zero so branches compare rn with r0
    task automatic jumpTrace();
        int trace [9] = '{0, 4, 5, 6, 2, 8, 9, 3, 3};
        clearProgram();
        prog[0] = immInstr(2'd2, 2'd0, 1'b0, 5'd0, 5'd0, 9'd4);     // Forward to 4
        prog[4] = immInstr(2'd1, 2'd0, 1'b1, 5'd1, 5'd0, 9'd7);
        prog[5] = immInstr(2'd1, 2'd0, 1'b1, 5'd2, 5'd0, 9'd0);
        prog[6] = immInstr(2'd2, 2'd0, 1'b1, 5'd0, 5'd0, 9'd4);     // Back to 2
        prog[2] = immInstr(2'd2, 2'd2, 1'b0, 5'd0, 5'd2, 9'd6);     // Equal so taken to 8
        prog[8] = immInstr(2'd2, 2'd2, 1'b1, 5'd0, 5'd1, 9'd7);     // Unequal so falls through
        prog[9] = immInstr(2'd2, 2'd2, 1'b1, 5'd0, 5'd2, 9'd6);     // Taken back to 3
        prog[3] = haltWord;
        resetCpu("jumps");
        for (int k = 0; k < 9; k++) begin
            @(negedge clk);
            compare("jumps", trace[k], instrAddr);
        end
    endtask

    task automatic linkAndReturn();
        int trace [7] = '{0, 1, 6, 7, 2, 3, 3};
        clearProgram();
        prog[0] = immInstr(2'd1, 2'd0, 1'b1, 5'd1, 5'd0, 9'd3);     // Store address
        prog[1] = immInstr(2'd2, 2'd1, 1'b0, 5'd0, 5'd0, 9'd5);     // BL to 6
        prog[6] = immInstr(2'd1, 2'd0, 1'b1, 5'd2, 5'd0, 9'h55);    // Subroutine body
        prog[7] = regInstr(2'd3, 2'd0, 5'd0, 5'd0, 5'd0);           // RET
        prog[2] = regInstr(2'd3, 2'd1, 5'(`LINK_REG), 5'd1, 5'd0);  // STR link reg
        prog[3] = haltWord;
        resetCpu("link");
        for (int k = 0; k < 7; k++) begin
            @(negedge clk);
            compare("link trace", trace[k], instrAddr);
        end
        checkPixel("link value", red, 3, 16'd2);                   // BL at 1 returns to 2
    endtask

    task automatic displayTiming();
        logic [15:0] oldVal, newVal;
        logic [5:0]  addrs [4] = '{6'd20, 6'd21, 6'd20, 6'd21};
        logic [15:0] words [4];
        oldVal = 16'($urandom % 512);
        newVal = oldVal ^ 16'h0155;                 // Always differs from oldVal
        clearProgram();
        prog[0] = immInstr(2'd1, 2'd0, 1'b1, 5'd1, 5'd0, oldVal[8:0]);
        prog[1] = immInstr(2'd1, 2'd0, 1'b1, 5'd2, 5'd0, newVal[8:0]);
        prog[2] = immInstr(2'd1, 2'd0, 1'b1, 5'd3, 5'd0, 9'd20);
        prog[3] = regInstr(2'd3, 2'd2, 5'd1, 5'd3, 5'd0);           // STG old at 20
        prog[4] = regInstr(2'd3, 2'd2, 5'd2, 5'd3, 5'd0);           // STG new at 20
        prog[5] = immInstr(2'd1, 2'd0, 1'b1, 5'd4, 5'd0, 9'd21);
        prog[6] = regInstr(2'd3, 2'd2, 5'd1, 5'd4, 5'd0);           // STG old at 21
        prog[7] = haltWord;
        resetCpu("display");
        runToAddr("display", 4);
        displayRead = 1'b1;                        // Same edge as the second store
        displayColor = green;
        displayAddr = 6'd20;
        @(posedge clk);
        #1;
        displayRead = 1'b0;
        @(negedge clk);
        compare("display same-cycle valid", 1, displayValid);
        compare("display same-cycle", newVal, displayData);
        runToAddr("display", 7);
        words = '{newVal, oldVal, newVal, oldVal};
        displayRead = 1'b1;
        displayAddr = addrs[0];
        for (int k = 0; k < 4; k++) begin
            @(posedge clk);
            #1;
            if (k < 3) displayAddr = addrs[k + 1];
            else       displayRead = 1'b0;
            @(negedge clk);
            compare("display burst valid", 1, displayValid);
            compare("display burst", words[k], displayData);
        end
        @(negedge clk);
        compare("display pulse end", 0, displayValid);
    endtask

    initial begin
        #(watchdogCycles * clkPeriod);
        $display("Watchdog expired before the tests finished");
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        reset = 1'b1;
        displayRead = 1'b0;
        displayColor = red;
        displayAddr = '0;
        clearProgram();
        void'($urandom(58));
        resetBehavior();
        finishTest("reset");
        arithmeticOps();
        finishTest("arithmetic");
        colourBanks();
        finishTest("banks");
        jumpTrace();
        finishTest("jumps");
        linkAndReturn();
        finishTest("link");
        displayTiming();
        finishTest("display");
        $display("Tests passed %0d failed %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+logic
logic/pixelCpuPkg.sv
logic/mainDecoder.sv
logic/aluUnit.sv
logic/registerFile.sv
logic/colorMemory.sv
logic/programCounter.sv
logic/pixelCpu.sv
verification/pixelCpuTb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module pixelCpuTb -f flist.f -o pixelCpuSim
./obj_dir/pixelCpuSim | tee sim.log

if grep -q "\*\*\* TEST PASSED \*\*\*" sim.log; then
    echo "Simulation result: pass"
else
    echo "Simulation result: fail"
    exit 1
fi
